// ==== rtl/melodyPkg.sv ====
// ROM word layout, bus widths and control opcodes shared by the melody player and its testbench
package melodyPkg;

	// word address and data width of the melody ROM bus
	localparam int ADDR_WIDTH = 12;
	localparam int DATA_WIDTH = 16;

	// control word opcodes
	localparam logic [2:0] OP_END  = 3'd0;
	localparam logic [2:0] OP_JUMP = 3'd1;

	// first word of a record, a note header or a control word
	typedef union packed {
		struct packed {
			logic        control;
			logic [14:0] durationMs;
		} note;
		struct packed {
			logic                  control;
			logic [2:0]            opcode;
			logic [ADDR_WIDTH-1:0] jumpAddress;
		} ctrl;
	} noteHeader_t;

endpackage

// ==== rtl/melodyRom.sv ====
// read-only Wishbone slave with the fixed melody table, one word per access
`timescale 1ns/1ps
`default_nettype none

module melodyRom (
	input  logic                             Clock,
	input  logic                             Reset,
	input  logic                             wbCyc_i,
	input  logic                             wbStb_i,
	input  logic [melodyPkg::ADDR_WIDTH-1:0] wbAdr_i,
	output logic [melodyPkg::DATA_WIDTH-1:0] wbDat_o,
	output logic                             wbAck_o
);
	import melodyPkg::*;

	// records are {0, durationMs} then halfPeriodUs; unused words read as end
	always_ff @(posedge Clock) begin
		if (wbCyc_i && wbStb_i) begin
			case (wbAdr_i)
				// 0x000: three notes then end
				12'h000: wbDat_o <= {1'b0, 15'd3};
				12'h001: wbDat_o <= 16'd100;
				12'h002: wbDat_o <= {1'b0, 15'd2};
				12'h003: wbDat_o <= 16'd50;
				12'h004: wbDat_o <= {1'b0, 15'd2};
				12'h005: wbDat_o <= 16'd200;
				12'h006: wbDat_o <= {1'b1, OP_END, 12'h000};
				// 0x010: note, rest, note
				12'h010: wbDat_o <= {1'b0, 15'd2};
				12'h011: wbDat_o <= 16'd80;
				12'h012: wbDat_o <= {1'b0, 15'd2};
				12'h013: wbDat_o <= 16'd0;
				12'h014: wbDat_o <= {1'b0, 15'd2};
				12'h015: wbDat_o <= 16'd40;
				12'h016: wbDat_o <= {1'b1, OP_END, 12'h000};
				// 0x020: two notes looping forever
				12'h020: wbDat_o <= {1'b0, 15'd1};
				12'h021: wbDat_o <= 16'd60;
				12'h022: wbDat_o <= {1'b0, 15'd1};
				12'h023: wbDat_o <= 16'd120;
				12'h024: wbDat_o <= {1'b1, OP_JUMP, 12'h020};
				// 0x030: one long note
				12'h030: wbDat_o <= {1'b0, 15'd20};
				12'h031: wbDat_o <= 16'd250;
				default: wbDat_o <= {1'b1, OP_END, 12'h000};
			endcase
		end
	end

	// single-cycle ack per strobe
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			wbAck_o <= 1'b0;
		end else begin
			wbAck_o <= wbCyc_i && wbStb_i && !wbAck_o;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/busArbiter.sv ====
// round-robin Wishbone arbiter sharing one slave between VOICE_COUNT masters
`timescale 1ns/1ps
`default_nettype none

module busArbiter #(
	parameter int VOICE_COUNT = 2
)(
	input  logic                                         Clock,
	input  logic                                         Reset,
	input  logic [VOICE_COUNT-1:0]                       mCyc_i,
	input  logic [VOICE_COUNT-1:0]                       mStb_i,
	input  logic [VOICE_COUNT*melodyPkg::ADDR_WIDTH-1:0] mAdr_i,
	output logic [melodyPkg::DATA_WIDTH-1:0]             mDat_o,
	output logic [VOICE_COUNT-1:0]                       mAck_o,
	output logic                                         sCyc_o,
	output logic                                         sStb_o,
	output logic [melodyPkg::ADDR_WIDTH-1:0]             sAdr_o,
	input  logic [melodyPkg::DATA_WIDTH-1:0]             sDat_i,
	input  logic                                         sAck_i
);
	import melodyPkg::*;

	localparam int IDX_WIDTH = (VOICE_COUNT > 1) ? $clog2(VOICE_COUNT) : 1;

	// owner while grantValid, last owner otherwise
	logic [IDX_WIDTH-1:0] rrPointer;
	logic                 grantValid;
	logic [IDX_WIDTH-1:0] nextOwner;
	logic                 pickValid;

	// first requester after the last owner
	always_comb begin
		int candidate;
		nextOwner = rrPointer;
		pickValid = 1'b0;
		for (int offset = 1; offset <= VOICE_COUNT; offset++) begin
			candidate = (int'(rrPointer) + offset) % VOICE_COUNT;
			if (!pickValid && mCyc_i[candidate]) begin
				nextOwner = IDX_WIDTH'(candidate);
				pickValid = 1'b1;
			end
		end
	end

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			grantValid <= 1'b0;
			rrPointer  <= IDX_WIDTH'(VOICE_COUNT - 1);
		end else if (grantValid) begin
			if (!mCyc_i[rrPointer])
				grantValid <= 1'b0;
		end else if (pickValid) begin
			grantValid <= 1'b1;
			rrPointer  <= nextOwner;
		end
	end

	assign sCyc_o = grantValid && mCyc_i[rrPointer];
	assign sStb_o = grantValid && mStb_i[rrPointer];
	assign sAdr_o = mAdr_i[rrPointer*ADDR_WIDTH +: ADDR_WIDTH];
	assign mDat_o = sDat_i;

	always_comb begin
		for (int i = 0; i < VOICE_COUNT; i++)
			mAck_o[i] = grantValid && (rrPointer == IDX_WIDTH'(i)) && sAck_i;
	end

	// an ack answers a request made under the same grant
	for (genvar i = 0; i < VOICE_COUNT; i++) begin : gAckCheck
		assert property (@(posedge Clock) disable iff (!Reset)
			mAck_o[i] |-> $past(grantValid && rrPointer == IDX_WIDTH'(i) && mCyc_i[i]));
	end

endmodule

`default_nettype wire

// ==== rtl/toneGenerator.sv ====
// square wave of a given half period for a given duration, started by a one-cycle pulse
`timescale 1ns/1ps
`default_nettype none

module toneGenerator #(
	parameter int CLOCK_HZ = 2_000_000
)(
	input  logic        Clock,
	input  logic        Reset,
	input  logic        start_i,
	input  logic        abort_i,
	input  logic [14:0] durationMs_i,
	input  logic [15:0] halfPeriodUs_i,
	output logic        soundWave_o,
	output logic        done_o
);
	localparam int US_CYCLES = CLOCK_HZ / 1_000_000;
	localparam int MS_CYCLES = CLOCK_HZ / 1000;
	localparam int US_WIDTH  = $clog2(US_CYCLES + 1);
	localparam int MS_WIDTH  = $clog2(MS_CYCLES + 1);

	logic                active;
	logic [US_WIDTH-1:0] usCount;
	logic [MS_WIDTH-1:0] msCount;
	logic [15:0]         halfCount;
	logic [14:0]         msElapsed;
	logic [15:0]         halfPeriodUs;
	logic [14:0]         durationMs;
	logic                usTick;
	logic                msTick;
	logic                lastMs;

	assign usTick = (usCount == US_WIDTH'(US_CYCLES - 1));
	assign msTick = (msCount == MS_WIDTH'(MS_CYCLES - 1));
	// zero duration ends on the first millisecond
	assign lastMs = (16'(msElapsed) + 16'd1 >= 16'(durationMs));
	assign done_o = active && msTick && lastMs;

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			active      <= 1'b0;
			usCount     <= '0;
			msCount     <= '0;
			halfCount   <= '0;
			msElapsed   <= '0;
			soundWave_o <= 1'b0;
		end else if (abort_i) begin
			active      <= 1'b0;
			soundWave_o <= 1'b0;
		end else if (start_i) begin
			active      <= 1'b1;
			usCount     <= '0;
			msCount     <= '0;
			halfCount   <= '0;
			msElapsed   <= '0;
			// rest keeps the wave low
			soundWave_o <= (halfPeriodUs_i != '0);
		end else if (active) begin
			usCount <= usTick ? '0 : usCount + 1'b1;
			msCount <= msTick ? '0 : msCount + 1'b1;
			if (msTick)
				msElapsed <= msElapsed + 1'b1;
			if (done_o) begin
				active      <= 1'b0;
				soundWave_o <= 1'b0;
			end else if (usTick && halfPeriodUs != '0) begin
				if (halfCount == halfPeriodUs - 1'b1) begin
					halfCount   <= '0;
					soundWave_o <= !soundWave_o;
				end else begin
					halfCount <= halfCount + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (start_i) begin
			halfPeriodUs <= halfPeriodUs_i;
			durationMs   <= durationMs_i;
		end
	end

	assert property (@(posedge Clock) disable iff (!Reset) done_o |=> !done_o);

endmodule

`default_nettype wire

// ==== rtl/voiceSequencer.sv ====
// one voice: fetches note records over Wishbone and plays them on its tone generator
`timescale 1ns/1ps
`default_nettype none

module voiceSequencer #(
	parameter int CLOCK_HZ = 2_000_000
)(
	input  logic                             Clock,
	input  logic                             Reset,
	input  logic                             play_i,
	input  logic                             stop_i,
	input  logic [melodyPkg::ADDR_WIDTH-1:0] startAddress_i,
	output logic                             wbCyc_o,
	output logic                             wbStb_o,
	output logic [melodyPkg::ADDR_WIDTH-1:0] wbAdr_o,
	input  logic [melodyPkg::DATA_WIDTH-1:0] wbDat_i,
	input  logic                             wbAck_i,
	output logic                             soundWave_o,
	output logic                             playing_o,
	output logic [melodyPkg::DATA_WIDTH-1:0] halfPeriod_o
);
	import melodyPkg::*;

	localparam logic [2:0] IDLE         = 3'd0;
	localparam logic [2:0] FETCH_HEADER = 3'd1;
	localparam logic [2:0] FETCH_HALF   = 3'd2;
	localparam logic [2:0] PLAY         = 3'd3;
	localparam logic [2:0] STOPPED      = 3'd4;

	logic [2:0]            state;
	logic [ADDR_WIDTH-1:0] recordAddr;
	logic [14:0]           durationMs;
	logic                  toneStart;
	logic                  toneDone;
	noteHeader_t           header;

	assign header = wbDat_i;

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			state        <= IDLE;
			recordAddr   <= '0;
			wbCyc_o      <= 1'b0;
			wbStb_o      <= 1'b0;
			wbAdr_o      <= '0;
			playing_o    <= 1'b0;
			toneStart    <= 1'b0;
			halfPeriod_o <= '0;
		end else begin
			toneStart <= 1'b0;
			if (stop_i && state != IDLE && state != STOPPED) begin
				// an open bus cycle still has to see its ack
				state        <= STOPPED;
				playing_o    <= 1'b0;
				halfPeriod_o <= '0;
				if (wbAck_i) begin
					wbCyc_o <= 1'b0;
					wbStb_o <= 1'b0;
				end
			end else begin
				case (state)
					IDLE: begin
						if (play_i && !stop_i) begin
							recordAddr <= startAddress_i;
							playing_o  <= 1'b1;
							state      <= FETCH_HEADER;
						end
					end
					FETCH_HEADER: begin
						if (!wbCyc_o) begin
							wbCyc_o <= 1'b1;
							wbStb_o <= 1'b1;
							wbAdr_o <= recordAddr;
						end else if (wbAck_i) begin
							wbCyc_o <= 1'b0;
							wbStb_o <= 1'b0;
							if (!header.note.control) begin
								state <= FETCH_HALF;
							end else if (header.ctrl.opcode == OP_JUMP) begin
								recordAddr <= header.ctrl.jumpAddress;
							end else begin
								state        <= IDLE;
								playing_o    <= 1'b0;
								halfPeriod_o <= '0;
							end
						end
					end
					FETCH_HALF: begin
						if (!wbCyc_o) begin
							wbCyc_o <= 1'b1;
							wbStb_o <= 1'b1;
							wbAdr_o <= recordAddr + 1'b1;
						end else if (wbAck_i) begin
							wbCyc_o      <= 1'b0;
							wbStb_o      <= 1'b0;
							halfPeriod_o <= wbDat_i;
							toneStart    <= 1'b1;
							state        <= PLAY;
						end
					end
					PLAY: begin
						if (toneDone) begin
							recordAddr <= recordAddr + ADDR_WIDTH'(2);
							state      <= FETCH_HEADER;
						end
					end
					STOPPED: begin
						if (wbAck_i) begin
							wbCyc_o <= 1'b0;
							wbStb_o <= 1'b0;
						end else if (!wbCyc_o) begin
							state <= IDLE;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// duration held from the header until the tone starts
	always_ff @(posedge Clock) begin
		if (state == FETCH_HEADER && wbAck_i)
			durationMs <= header.note.durationMs;
	end

	toneGenerator #(
		.CLOCK_HZ(CLOCK_HZ)
	) i_toneGenerator (
		.Clock         (Clock),
		.Reset         (Reset),
		.start_i       (toneStart),
		.abort_i       (stop_i),
		.durationMs_i  (durationMs),
		.halfPeriodUs_i(halfPeriod_o),
		.soundWave_o   (soundWave_o),
		.done_o        (toneDone)
	);

	assert property (@(posedge Clock) disable iff (!Reset) $rose(wbStb_o) |-> wbCyc_o);
	assert property (@(posedge Clock) disable iff (!Reset)
		(wbStb_o && !wbAck_i) |=> $stable(wbAdr_o));

endmodule

`default_nettype wire

// ==== rtl/melodyPlayerTop.sv ====
// two-voice melody player, both voices reading the shared melody ROM through the arbiter
`timescale 1ns/1ps
`default_nettype none

module melodyPlayerTop #(
	parameter int CLOCK_HZ = 2_000_000
)(
	input  logic                             Clock,
	input  logic                             Reset,
	input  logic [1:0]                       play_i,
	input  logic [1:0]                       stop_i,
	input  logic [melodyPkg::ADDR_WIDTH-1:0] startAddress0_i,
	input  logic [melodyPkg::ADDR_WIDTH-1:0] startAddress1_i,
	output logic [1:0]                       soundWave_o,
	output logic [1:0]                       playing_o,
	output logic [15:0]                      halfPeriod0_o,
	output logic [15:0]                      halfPeriod1_o
);
	import melodyPkg::*;

	localparam int VOICE_COUNT = 2;

	logic [VOICE_COUNT-1:0]            mCyc;
	logic [VOICE_COUNT-1:0]            mStb;
	logic [VOICE_COUNT*ADDR_WIDTH-1:0] mAdr;
	logic [DATA_WIDTH-1:0]             mDat;
	logic [VOICE_COUNT-1:0]            mAck;
	logic                              romCyc;
	logic                              romStb;
	logic [ADDR_WIDTH-1:0]             romAdr;
	logic [DATA_WIDTH-1:0]             romDat;
	logic                              romAck;

	voiceSequencer #(
		.CLOCK_HZ(CLOCK_HZ)
	) i_voice0 (
		.Clock         (Clock),
		.Reset         (Reset),
		.play_i        (play_i[0]),
		.stop_i        (stop_i[0]),
		.startAddress_i(startAddress0_i),
		.wbCyc_o       (mCyc[0]),
		.wbStb_o       (mStb[0]),
		.wbAdr_o       (mAdr[0 +: ADDR_WIDTH]),
		.wbDat_i       (mDat),
		.wbAck_i       (mAck[0]),
		.soundWave_o   (soundWave_o[0]),
		.playing_o     (playing_o[0]),
		.halfPeriod_o  (halfPeriod0_o)
	);

	voiceSequencer #(
		.CLOCK_HZ(CLOCK_HZ)
	) i_voice1 (
		.Clock         (Clock),
		.Reset         (Reset),
		.play_i        (play_i[1]),
		.stop_i        (stop_i[1]),
		.startAddress_i(startAddress1_i),
		.wbCyc_o       (mCyc[1]),
		.wbStb_o       (mStb[1]),
		.wbAdr_o       (mAdr[ADDR_WIDTH +: ADDR_WIDTH]),
		.wbDat_i       (mDat),
		.wbAck_i       (mAck[1]),
		.soundWave_o   (soundWave_o[1]),
		.playing_o     (playing_o[1]),
		.halfPeriod_o  (halfPeriod1_o)
	);

	busArbiter #(
		.VOICE_COUNT(VOICE_COUNT)
	) i_arbiter (
		.Clock (Clock),
		.Reset (Reset),
		.mCyc_i(mCyc),
		.mStb_i(mStb),
		.mAdr_i(mAdr),
		.mDat_o(mDat),
		.mAck_o(mAck),
		.sCyc_o(romCyc),
		.sStb_o(romStb),
		.sAdr_o(romAdr),
		.sDat_i(romDat),
		.sAck_i(romAck)
	);

	melodyRom i_rom (
		.Clock  (Clock),
		.Reset  (Reset),
		.wbCyc_i(romCyc),
		.wbStb_i(romStb),
		.wbAdr_i(romAdr),
		.wbDat_o(romDat),
		.wbAck_o(romAck)
	);

endmodule

`default_nettype wire

// ==== dv/melodyPlayerTb.sv ====
// self-checking testbench for the melody player, runs the tests listed in the vector file
`timescale 1ns/1ps

module melodyPlayerTb;
	import melodyPkg::*;

	localparam int CLOCK_HZ    = 2_000_000;
	localparam int MAX_NOTES   = 8;
	localparam int WAIT_CYCLES = 100;

	logic                  Clock;
	logic                  Reset;
	logic [1:0]            play;
	logic [1:0]            stop;
	logic [ADDR_WIDTH-1:0] startAddress0;
	logic [ADDR_WIDTH-1:0] startAddress1;
	logic [1:0]            soundWave;
	logic [1:0]            playing;
	logic [15:0]           halfPeriod0;
	logic [15:0]           halfPeriod1;

	int         vectorFile;
	string      testName;
	logic [1:0] playMask;
	int         addr0;
	int         addr1;
	int         stopDelay;
	int         noteCount [2];
	int         expHp [2][MAX_NOTES];
	int         expDur [2][MAX_NOTES];
	int         failCount;
	int         testCount;
	int         badTests;

	melodyPlayerTop #(
		.CLOCK_HZ(CLOCK_HZ)
	) i_dut (
		.Clock          (Clock),
		.Reset          (Reset),
		.play_i         (play),
		.stop_i         (stop),
		.startAddress0_i(startAddress0),
		.startAddress1_i(startAddress1),
		.soundWave_o    (soundWave),
		.playing_o      (playing),
		.halfPeriod0_o  (halfPeriod0),
		.halfPeriod1_o  (halfPeriod1)
	);

	always #4 Clock = ~Clock;

	function automatic logic [15:0] halfPeriodOf(input int voice);
		return (voice == 0) ? halfPeriod0 : halfPeriod1;
	endfunction

	// one test line, comment lines skipped
	task automatic readVector(output bit ok);
		string token;
		string rest;
		int code;
		ok = 0;
		while (!ok) begin
			code = $fscanf(vectorFile, "%s", token);
			if (code != 1)
				return;
			if (token.substr(0, 0) == "#") begin
				code = $fgets(rest, vectorFile);
			end else begin
				testName = token;
				code = $fscanf(vectorFile, "%d %h %h %d", playMask, addr0, addr1, stopDelay);
				ok = (code == 4);
				for (int v = 0; v < 2; v++) begin
					code = $fscanf(vectorFile, "%d", noteCount[v]);
					ok = ok && (code == 1) && (noteCount[v] <= MAX_NOTES);
					for (int n = 0; n < noteCount[v] && ok; n++) begin
						code = $fscanf(vectorFile, "%d %d", expHp[v][n], expDur[v][n]);
						ok = (code == 2);
					end
				end
				assert (ok) else begin
					$display("vector line of test %s is malformed", testName);
					failCount++;
					return;
				end
			end
		end
	endtask

	// each wave level against the half period, then the whole note against the duration
	task automatic measureNote(input int voice, input int hp, input int dur);
		int levelCycles;
		int noteCycles;
		int elapsed;
		int expected;
		int limit;
		int run;
		logic level;
		bit found;
		found = 0;
		for (int t = 0; t < WAIT_CYCLES && !found; t++) begin
			@(negedge Clock);
			found = (halfPeriodOf(voice) == 16'(hp));
		end
		assert (found) else begin
			$display("Error %s voice %0d: half period expected %0d, actual %0d",
				testName, voice, hp, halfPeriodOf(voice));
			failCount++;
		end
		if (!found)
			return;
		noteCycles  = dur * (CLOCK_HZ / 1000);
		levelCycles = (hp == 0) ? noteCycles : hp * CLOCK_HZ / 1_000_000;
		level       = (hp != 0);
		elapsed     = 0;
		@(negedge Clock);
		while (elapsed < noteCycles) begin
			expected = (levelCycles < noteCycles - elapsed) ? levelCycles : noteCycles - elapsed;
			// a last low level runs into the fetch gap
			limit = level ? noteCycles - elapsed + 1 : noteCycles - elapsed;
			run   = 0;
			while (run < limit && soundWave[voice] == level) begin
				run++;
				@(negedge Clock);
			end
			elapsed += run;
			assert (run == expected) else begin
				$display("Error %s voice %0d: level %b cycles expected %0d, actual %0d",
					testName, voice, level, expected, run);
				failCount++;
				break;
			end
			level = !level;
		end
		assert (elapsed == noteCycles) else begin
			$display("Error %s voice %0d: note cycles expected %0d, actual %0d",
				testName, voice, noteCycles, elapsed);
			failCount++;
		end
	endtask

	task automatic playVoice(input int voice);
		bit quiet;
		for (int n = 0; n < noteCount[voice]; n++)
			measureNote(voice, expHp[voice][n], expDur[voice][n]);
		if (stopDelay == 0) begin
			quiet = 0;
			for (int t = 0; t < WAIT_CYCLES && !quiet; t++) begin
				@(negedge Clock);
				quiet = !playing[voice];
			end
			assert (quiet) else begin
				$display("voice %0d in test %s kept playing after its end word", voice, testName);
				failCount++;
			end
		end
	endtask

	task automatic applyStop();
		bit quiet;
		repeat (stopDelay) @(negedge Clock);
		assert ((playing & playMask) == playMask) else begin
			$display("Error %s: playing before stop expected %b, actual %b",
				testName, playMask, playing);
			failCount++;
		end
		@(posedge Clock);
		stop  <= playMask;
		quiet = 0;
		for (int t = 0; t < 3 && !quiet; t++) begin
			@(negedge Clock);
			quiet = (((soundWave | playing) & playMask) == 2'b00);
		end
		assert (quiet) else begin
			$display("wave or playing of test %s still high 2 cycles after stop", testName);
			failCount++;
		end
		repeat (4) @(posedge Clock);
		stop <= 2'b00;
	endtask

	task automatic reportTest(input int failsBefore);
		testCount++;
		if (failCount == failsBefore) begin
			$display("test %s: ok", testName);
		end else begin
			badTests++;
			$display("test %s: %0d errors", testName, failCount - failsBefore);
		end
	endtask

	initial begin
		bit ok;
		int failsBefore;
		Clock = 0;
		Reset = 0;
		play = 2'b00;
		stop = 2'b00;
		startAddress0 = '0;
		startAddress1 = '0;
		failCount = 0;
		testCount = 0;
		badTests = 0;
		repeat (10) @(posedge Clock);
		Reset <= 1'b1;

		testName = "reset";
		for (int c = 0; c < 20; c++) begin
			@(negedge Clock);
			assert (soundWave == 2'b00 && playing == 2'b00) else begin
				$display("Error reset: wave and playing expected 0000, actual %b%b",
					soundWave, playing);
				failCount++;
			end
		end
		reportTest(0);

		vectorFile = $fopen("dv/melodyVectors.txt", "r");
		assert (vectorFile != 0) else begin
			$display("could not open the vector file");
			failCount++;
		end
		ok = (vectorFile != 0);
		while (ok) begin
			readVector(ok);
			if (ok) begin
				failsBefore = failCount;
				@(posedge Clock);
				startAddress0 <= ADDR_WIDTH'(addr0);
				startAddress1 <= ADDR_WIDTH'(addr1);
				play          <= playMask;
				@(posedge Clock);
				play <= 2'b00;
				@(negedge Clock);
				assert ((playing & playMask) == playMask) else begin
					$display("Error %s: playing expected %b, actual %b", testName, playMask, playing);
					failCount++;
				end
				fork
					begin
						if (playMask[0])
							playVoice(0);
					end
					begin
						if (playMask[1])
							playVoice(1);
					end
					begin
						if (stopDelay != 0)
							applyStop();
					end
				join
				repeat (20) @(posedge Clock);
				reportTest(failsBefore);
			end
		end

		$display("%0d tests, %0d with errors, %0d failed checks", testCount, badTests, failCount);
		if (failCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
rtl/melodyPkg.sv
rtl/melodyRom.sv
rtl/busArbiter.sv
rtl/toneGenerator.sv
rtl/voiceSequencer.sv
rtl/melodyPlayerTop.sv
dv/melodyPlayerTb.sv

// ==== dv/melodyVectors.txt ====
# name mask addr0 addr1 stopDelay, then per voice: noteCount and that many halfPeriodUs durationMs pairs
# addresses in hex, all other columns decimal; stopDelay counts cycles after play, 0 means no stop
single 1 000 000 0 3 100 3 50 2 200 2 0
rest 1 010 000 0 3 80 2 0 2 40 2 0
loop 1 020 000 9000 4 60 1 120 1 60 1 120 1 0
bothDiff 3 000 010 0 3 100 3 50 2 200 2 3 80 2 0 2 40 2
bothSame 3 000 000 0 3 100 3 50 2 200 2 3 100 3 50 2 200 2
voice1Rest 2 000 010 0 0 3 80 2 0 2 40 2
stopLong 1 030 000 10000 0 0
stopMid 1 000 000 7000 1 100 3 0
restart 1 000 000 0 3 100 3 50 2 200 2 0
restartLong 1 030 000 0 1 250 20 0
